// ==== include/pat_consts.svh ====
`ifndef PAT_CONSTS_SVH
`define PAT_CONSTS_SVH

// widths and depths
`define PAT_INSTR_W     20
`define PAT_PC_W        10
`define PAT_IMEM_DEPTH  64
`define PAT_IMEM_AW     6       // log2 of imem depth
`define PAT_DATA_W      8
`define PAT_DMEM_DEPTH  8
`define PAT_DMEM_AW     3

// escape into the next group down
`define PAT_PREFIX      4'b1111

// AL, group i0 opcode 1111
`define PAT_NOP         20'h06fff

// eight-bit immediate group, bits 11:8
`define PAT_OP8_OR      4'h0
`define PAT_OP8_AND     4'h1
`define PAT_OP8_ADDM    4'h2
`define PAT_OP8_SUBM    4'h3
`define PAT_OP8_ADD     4'h4
`define PAT_OP8_SUB     4'h5
`define PAT_OP8_LDI     4'h6
`define PAT_OP8_LDM     4'h7
`define PAT_OP8_BF      4'h8
`define PAT_OP8_STM     4'hb
`define PAT_OP8_ORM     4'hd
`define PAT_OP8_ANDM    4'he

// three-bit immediate group, bits 7:4
`define PAT_OP3_SHL     4'h0
`define PAT_OP3_SHLO    4'h1
`define PAT_OP3_SHR     4'h2
`define PAT_OP3_ASR     4'h3
`define PAT_OP3_IN      4'h5
`define PAT_OP3_OUT     4'h8

// zero-immediate group, bits 3:0
`define PAT_OP0_NOT     4'h0
`define PAT_OP0_TEST    4'h2
`define PAT_OP0_NOP     4'hf

// predicate field, bits 14:13
`define PAT_COND_Z      2'd0
`define PAT_COND_NZ     2'd1
`define PAT_COND_N      2'd2
`define PAT_COND_AL     2'd3

`endif

// ==== design/pat_pkg.sv ====
`default_nettype none

`include "pat_consts.svh"

package pat_pkg;

	typedef logic [`PAT_INSTR_W-1:0] instr_t;
	typedef logic [`PAT_PC_W-1:0]    pc_t;
	typedef logic [`PAT_DATA_W-1:0]  data_t;

	// predicate, tested against z and n in execute
	typedef enum logic [1:0]
	{
		COND_Z  = `PAT_COND_Z,
		COND_NZ = `PAT_COND_NZ,
		COND_N  = `PAT_COND_N,
		COND_AL = `PAT_COND_AL
	} cond_e;

	typedef enum logic [3:0]
	{
		ALU_OR   = 4'd0,
		ALU_AND  = 4'd1,
		ALU_ADD  = 4'd2,
		ALU_SUB  = 4'd3,
		ALU_NOT  = 4'd4,
		ALU_SHL  = 4'd5,
		ALU_SHLO = 4'd6,
		ALU_SHR  = 4'd7,
		ALU_ASR  = 4'd8,
		ALU_PASS = 4'd9     // loads, b straight through
	} alu_op_e;

	// program load strobe into imem
	typedef struct packed
	{
		logic                    en;
		logic [`PAT_IMEM_AW-1:0] addr;
		instr_t                  instr;
	} prog_wr_t;

	typedef struct packed
	{
		logic   valid;
		pc_t    pc;
		instr_t instr;
	} fetch_t;

	// control for one instruction in execute
	typedef struct packed
	{
		logic                    valid;
		pc_t                     pc;        // own address, branch base
		cond_e                   cond;
		alu_op_e                 alu_op;
		data_t                   imm;       // zero-extended
		logic                    mem_op;    // operand b from dmem
		logic [`PAT_DMEM_AW-1:0] dmem_addr;
		logic                    wr_acc;
		logic                    store;
		logic                    test;
		logic                    port_out;
		logic                    port_in;
		logic                    branch;
	} decode_t;

endpackage

`default_nettype wire

// ==== design/pat_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module pat_alu
(
	input  wire pat_pkg::alu_op_e i_op,
	input  wire pat_pkg::data_t   i_a,      // accumulator
	input  wire pat_pkg::data_t   i_b,      // imm, dmem word or input port
	output pat_pkg::data_t        o_y
);

	logic [2:0]     sh;
	pat_pkg::data_t ones;

	// shift count from the low bits only
	assign sh   = i_b[2:0];
	assign ones = ~({$bits(pat_pkg::data_t){1'b1}} << sh);    // fill for shlo

	always_comb
	begin
		case (i_op)
			pat_pkg::ALU_OR:   o_y = i_a | i_b;
			pat_pkg::ALU_AND:  o_y = i_a & i_b;
			pat_pkg::ALU_ADD:  o_y = i_a + i_b;     // wraps mod 256
			pat_pkg::ALU_SUB:  o_y = i_a - i_b;
			pat_pkg::ALU_NOT:  o_y = ~i_a;

			// ============================================================
			// shifter
			// ============================================================
			pat_pkg::ALU_SHL:  o_y = i_a << sh;
			pat_pkg::ALU_SHLO: o_y = (i_a << sh) | ones;
			pat_pkg::ALU_SHR:  o_y = i_a >> sh;
			pat_pkg::ALU_ASR:  o_y = pat_pkg::data_t'($signed(i_a) >>> sh);   // keep sign

			// ldi, ldm, in
			pat_pkg::ALU_PASS: o_y = i_b;
			default:           o_y = i_b;
		endcase
	end

endmodule

`default_nettype wire

// ==== design/pat_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pat_consts.svh"

module pat_fetch
(
	input  wire                    clk,
	input  wire                    reset,
	input  wire pat_pkg::prog_wr_t i_prog,
	input  wire                    i_redirect,
	input  wire pat_pkg::pc_t      i_target,
	output pat_pkg::fetch_t        o_fetch,
	output pat_pkg::pc_t           o_pc
);

	pat_pkg::instr_t imem [`PAT_IMEM_DEPTH];  // program store
	pat_pkg::pc_t    pc_q;
	pat_pkg::pc_t    pc_next;

	// ====================================================================
	// program counter
	// ====================================================================

	// taken branch wins over sequential fetch
	assign pc_next = i_redirect ? i_target : pc_q + 1'b1;

	always_ff @(posedge clk)
	begin
		if (reset)
			pc_q <= '0;                         // start from word 0
		else
			pc_q <= pc_next;
	end

	assign o_pc = pc_q;

	// ====================================================================
	// instruction memory
	// ====================================================================

	// write port open at any time, tb only drives it in reset
	always_ff @(posedge clk)
	begin
		if (i_prog.en)
			imem[i_prog.addr] <= i_prog.instr;
	end

	// synchronous read, one word per cycle
	// upper pc bits ignored so the store wraps every 64 words
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_fetch.valid <= 1'b0;
			o_fetch.instr <= `PAT_NOP;
		end
		else
		begin
			// word read alongside a redirect is the wrong path
			o_fetch.valid <= ~i_redirect;
			o_fetch.instr <= i_redirect ? `PAT_NOP : imem[pc_q[`PAT_IMEM_AW-1:0]];
		end
		o_fetch.pc <= pc_q;                     // address travels with its word
	end

endmodule

`default_nettype wire

// ==== design/pat_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pat_consts.svh"

module pat_decode
(
	input  wire                  clk,
	input  wire                  reset,
	input  wire pat_pkg::fetch_t i_fetch,
	input  wire                  i_squash,
	output pat_pkg::decode_t     o_dec
);

	logic [1:0]        cond_f;
	logic [3:0]        op8;
	logic [3:0]        op3;
	logic [3:0]        op0;
	logic [7:0]        imm8;
	logic [2:0]        imm3;
	logic              is_i8;
	logic              is_i3;
	logic              no_op;
	pat_pkg::decode_t  dec_d;

	// ====================================================================
	// field split
	// ====================================================================
	// 19:15 field pointer and 12 field-op flag are reserved, never looked at
	assign cond_f = i_fetch.instr[14:13];
	assign op8    = i_fetch.instr[11:8];
	assign imm8   = i_fetch.instr[7:0];
	assign op3    = i_fetch.instr[7:4];     // only meaningful under the prefix
	assign imm3   = i_fetch.instr[2:0];
	assign op0    = i_fetch.instr[3:0];

	// three-level prefix, 1111 drops one group
	assign is_i8 = (op8 != `PAT_PREFIX);
	assign is_i3 = ~is_i8 && (op3 != `PAT_PREFIX);

	always_comb
	begin
		dec_d = '0;
		no_op = 1'b0;
		dec_d.valid     = i_fetch.valid & ~i_squash;    // kill on redirect
		dec_d.pc        = i_fetch.pc;
		dec_d.cond      = pat_pkg::cond_e'(cond_f);
		dec_d.alu_op    = pat_pkg::ALU_PASS;
		dec_d.imm       = is_i8 ? imm8 : {{(`PAT_DATA_W-3){1'b0}}, imm3};
		dec_d.dmem_addr = imm8[`PAT_DMEM_AW-1:0];

		if (is_i8)
		begin
			case (op8)
				`PAT_OP8_OR:   dec_d.alu_op = pat_pkg::ALU_OR;
				`PAT_OP8_AND:  dec_d.alu_op = pat_pkg::ALU_AND;
				`PAT_OP8_ADD:  dec_d.alu_op = pat_pkg::ALU_ADD;
				`PAT_OP8_SUB:  dec_d.alu_op = pat_pkg::ALU_SUB;
				`PAT_OP8_ADDM: dec_d.alu_op = pat_pkg::ALU_ADD;
				`PAT_OP8_SUBM: dec_d.alu_op = pat_pkg::ALU_SUB;
				`PAT_OP8_ORM:  dec_d.alu_op = pat_pkg::ALU_OR;
				`PAT_OP8_ANDM: dec_d.alu_op = pat_pkg::ALU_AND;
				`PAT_OP8_LDI:  dec_d.alu_op = pat_pkg::ALU_PASS;
				`PAT_OP8_LDM:  dec_d.alu_op = pat_pkg::ALU_PASS;
				`PAT_OP8_STM:  dec_d.store = 1'b1;
				`PAT_OP8_BF:   dec_d.branch = 1'b1;
				default:       no_op = 1'b1;            // old bb, call, setsp
			endcase
			// memory forms read dmem[imm[2:0]] as operand b
			dec_d.mem_op = op8 inside {`PAT_OP8_LDM, `PAT_OP8_ADDM,
				`PAT_OP8_SUBM, `PAT_OP8_ORM, `PAT_OP8_ANDM};
		end
		else if (is_i3)
		begin
			case (op3)
				`PAT_OP3_SHL:  dec_d.alu_op = pat_pkg::ALU_SHL;
				`PAT_OP3_SHLO: dec_d.alu_op = pat_pkg::ALU_SHLO;
				`PAT_OP3_SHR:  dec_d.alu_op = pat_pkg::ALU_SHR;
				`PAT_OP3_ASR:  dec_d.alu_op = pat_pkg::ALU_ASR;
				`PAT_OP3_IN:   dec_d.port_in = 1'b1;    // pass of the input port
				`PAT_OP3_OUT:  dec_d.port_out = 1'b1;
				default:       no_op = 1'b1;
			endcase
		end
		else
		begin
			case (op0)
				`PAT_OP0_NOT:  dec_d.alu_op = pat_pkg::ALU_NOT;
				`PAT_OP0_TEST: dec_d.test = 1'b1;
				`PAT_OP0_NOP:  no_op = 1'b1;
				default:       no_op = 1'b1;            // undefined acts as nop
			endcase
		end

		// everything else lands in the accumulator
		dec_d.wr_acc = ~(dec_d.store | dec_d.branch | dec_d.port_out
			| dec_d.test | no_op);
	end

	always_ff @(posedge clk)
	begin
		o_dec <= dec_d;
		if (reset)
			o_dec.valid <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== design/pat_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pat_consts.svh"

module pat_execute
(
	input  wire                   clk,
	input  wire                   reset,
	input  wire pat_pkg::decode_t i_dec,
	input  wire pat_pkg::data_t   i_in_port,
	output logic                  o_redirect,
	output pat_pkg::pc_t          o_target,
	output pat_pkg::data_t        o_out_port,
	output logic                  o_out_valid
);

	pat_pkg::data_t acc_q;                          // the accumulator
	logic           z_q;                            // zero flag, test only
	logic           n_q;                            // sign flag, test only
	pat_pkg::data_t dmem [`PAT_DMEM_DEPTH];
	pat_pkg::data_t dmem_rd;
	pat_pkg::data_t alu_b;
	pat_pkg::data_t alu_y;
	logic           cond_ok;
	logic           fire;

	// ====================================================================
	// predicate
	// ====================================================================
	always_comb
	begin
		case (i_dec.cond)
			pat_pkg::COND_Z:  cond_ok = z_q;
			pat_pkg::COND_NZ: cond_ok = ~z_q;
			pat_pkg::COND_N:  cond_ok = n_q;
			default:          cond_ok = 1'b1;       // al
		endcase
	end

	// squashed slots and false predicates do nothing
	assign fire = i_dec.valid & cond_ok;

	// ====================================================================
	// operand select and alu
	// ====================================================================
	// same-cycle read, so a store is seen by the very next load
	assign dmem_rd = dmem[i_dec.dmem_addr];

	always_comb
	begin
		if (i_dec.port_in)
			alu_b = i_in_port;
		else if (i_dec.mem_op)
			alu_b = dmem_rd;
		else
			alu_b = i_dec.imm;
	end

	pat_alu alu
	(
		.i_op (i_dec.alu_op),
		.i_a  (acc_q),
		.i_b  (alu_b),
		.o_y  (alu_y)
	);

	// bf, own pc plus signed offset; offset 0 spins in place
	assign o_redirect = fire & i_dec.branch;
	assign o_target   = i_dec.pc
		+ {{(`PAT_PC_W-`PAT_DATA_W){i_dec.imm[`PAT_DATA_W-1]}}, i_dec.imm};

	// ====================================================================
	// commit
	// ====================================================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			acc_q <= '0;
			z_q   <= 1'b0;
			n_q   <= 1'b0;
		end
		else if (fire)
		begin
			if (i_dec.wr_acc)
				acc_q <= alu_y;
			if (i_dec.test)
			begin
				z_q <= (acc_q == '0);
				n_q <= acc_q[`PAT_DATA_W-1];
			end
		end
	end

	// data memory, cleared so unwritten words read zero
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `PAT_DMEM_DEPTH; i++)
				dmem[i] <= '0;
		end
		else if (fire && i_dec.store)
			dmem[i_dec.dmem_addr] <= acc_q;
	end

	// output port, value held until the next out
	always_ff @(posedge clk)
	begin
		if (reset)
			o_out_valid <= 1'b0;
		else
			o_out_valid <= fire & i_dec.port_out;  // one-cycle strobe
		if (fire && i_dec.port_out)
			o_out_port <= acc_q;
	end

endmodule

`default_nettype wire

// ==== design/pat_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pat_top
(
	input  wire                    clk,
	input  wire                    reset,
	input  wire pat_pkg::prog_wr_t i_prog,
	input  wire pat_pkg::data_t    i_in_port,
	output pat_pkg::data_t         o_out_port,
	output logic                   o_out_valid,
	output pat_pkg::pc_t           o_pc
);

	pat_pkg::fetch_t  fetch_w;                  // fetch to decode
	pat_pkg::decode_t dec_w;                    // decode to execute
	logic             redirect;                 // taken branch, back to both
	pat_pkg::pc_t     target;

	// ====================================================================
	// fetch, decode, execute
	// ====================================================================
	pat_fetch fetch
	(
		.clk        (clk),
		.reset      (reset),
		.i_prog     (i_prog),
		.i_redirect (redirect),
		.i_target   (target),
		.o_fetch    (fetch_w),
		.o_pc       (o_pc)
	);

	pat_decode decode
	(
		.clk      (clk),
		.reset    (reset),
		.i_fetch  (fetch_w),
		.i_squash (redirect),                   // second wrong-path slot
		.o_dec    (dec_w)
	);

	pat_execute execute
	(
		.clk         (clk),
		.reset       (reset),
		.i_dec       (dec_w),
		.i_in_port   (i_in_port),
		.o_redirect  (redirect),
		.o_target    (target),
		.o_out_port  (o_out_port),
		.o_out_valid (o_out_valid)
	);

endmodule

`default_nettype wire

// ==== test/pat_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module pat_exec_chk
(
	input wire                   clk,
	input wire                   reset,
	input wire pat_pkg::decode_t i_dec,
	input wire                   i_redirect,
	input wire                   i_out_valid
);

	int fails = 0;                                 // failed assertion count

	// ==================================================================
	// output strobe
	// ==================================================================
	assert property (@(posedge clk) disable iff (reset) i_out_valid |=> !i_out_valid)
	else
	begin
		$error("out valid high two cycles in a row");
		fails++;
	end

	assert property (@(posedge clk) reset |=> !i_out_valid)
	else
	begin
		$error("out valid raised during reset");
		fails++;
	end

	// two wrong-path slots behind a taken branch
	assert property (@(posedge clk) disable iff (reset)
		i_redirect |=> !i_dec.valid ##1 !i_dec.valid)
	else
	begin
		$error("valid slot reached execute right after a redirect");
		fails++;
	end

endmodule

bind pat_execute pat_exec_chk exec_chk
(
	.clk         (clk),
	.reset       (reset),
	.i_dec       (i_dec),
	.i_redirect  (o_redirect),
	.i_out_valid (o_out_valid)
);

`default_nettype wire

// ==== test/pat_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pat_consts.svh"

module pat_tb;

	localparam int WAIT_LIMIT = 2000;              // cycles allowed for the expected outputs
	localparam int TAIL       = 40;                // quiet cycles watched afterwards

	logic              clk;
	logic              reset;
	pat_pkg::prog_wr_t i_prog;
	pat_pkg::data_t    i_in_port;
	pat_pkg::data_t    o_out_port;
	logic              o_out_valid;
	pat_pkg::pc_t      o_pc;

	pat_pkg::instr_t prog [16];                    // program of the current test
	int              prog_len;
	pat_pkg::data_t  exp_q [$];                    // predicted out values in program order
	int              out_idx;                      // outputs seen so far
	int              checked;
	int              errors;
	int              seed;
	string           test_name;

	pat_top dut
	(
		.clk         (clk),
		.reset       (reset),
		.i_prog      (i_prog),
		.i_in_port   (i_in_port),
		.o_out_port  (o_out_port),
		.o_out_valid (o_out_valid),
		.o_pc        (o_pc)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;                     // 4 ns period
	end

	// ====================================================================
	// program building
	// ====================================================================
	function automatic pat_pkg::instr_t imm8_word(input logic [1:0] cond,
		input logic [3:0] op, input logic [7:0] imm);
		return {5'b0, cond, 1'b0, op, imm};        // reserved bits left zero
	endfunction

	function automatic pat_pkg::instr_t imm3_word(input logic [1:0] cond,
		input logic [3:0] op, input logic [2:0] sh);
		return {5'b0, cond, 1'b0, `PAT_PREFIX, op, 1'b0, sh};
	endfunction

	function automatic pat_pkg::instr_t imm0_word(input logic [1:0] cond,
		input logic [3:0] op);
		return {5'b0, cond, 1'b0, `PAT_PREFIX, `PAT_PREFIX, op};
	endfunction

	function automatic pat_pkg::data_t rand_byte();
		return pat_pkg::data_t'($random(seed));
	endfunction

	task automatic new_program(input string name);
		test_name = name;
		prog_len  = 0;
	endtask

	task automatic add_word(input pat_pkg::instr_t w);
		prog[prog_len] = w;
		prog_len++;
	endtask

	task automatic add_out();
		add_word(imm3_word(`PAT_COND_AL, `PAT_OP3_OUT, 3'd0));
	endtask

	task automatic add_halt();
		add_word(imm8_word(`PAT_COND_AL, `PAT_OP8_BF, 8'h00));   // branch to itself
	endtask

	// ====================================================================
	// reference interpreter
	// ====================================================================
	function automatic void predict(input pat_pkg::data_t in_val);
		pat_pkg::data_t  acc;
		pat_pkg::data_t  mem [`PAT_DMEM_DEPTH];
		pat_pkg::data_t  imm;
		pat_pkg::instr_t w;
		logic [2:0]      sh;
		logic            z;
		logic            n;
		logic            ok;
		logic            halted;
		int              pc;
		int              next_pc;
		int              steps;
		int              k;
		acc    = '0;
		z      = 1'b0;
		n      = 1'b0;
		halted = 1'b0;
		pc     = 0;
		steps  = 0;
		for (k = 0; k < `PAT_DMEM_DEPTH; k++)
			mem[k] = '0;
		exp_q.delete();
		while (!halted && steps < 200)
		begin
			w       = (pc < prog_len) ? prog[pc] : `PAT_NOP;
			imm     = w[7:0];
			sh      = w[2:0];
			next_pc = pc + 1;
			case (w[14:13])
				`PAT_COND_Z:  ok = z;
				`PAT_COND_NZ: ok = !z;
				`PAT_COND_N:  ok = n;
				default:      ok = 1'b1;
			endcase
			if (ok && w[11:8] != `PAT_PREFIX)
			begin
				case (w[11:8])
					`PAT_OP8_OR:   acc = acc | imm;
					`PAT_OP8_AND:  acc = acc & imm;
					`PAT_OP8_ADD:  acc = acc + imm;      // wraps
					`PAT_OP8_SUB:  acc = acc - imm;
					`PAT_OP8_LDI:  acc = imm;
					`PAT_OP8_LDM:  acc = mem[imm[2:0]];
					`PAT_OP8_STM:  mem[imm[2:0]] = acc;
					`PAT_OP8_ADDM: acc = acc + mem[imm[2:0]];
					`PAT_OP8_SUBM: acc = acc - mem[imm[2:0]];
					`PAT_OP8_ORM:  acc = acc | mem[imm[2:0]];
					`PAT_OP8_ANDM: acc = acc & mem[imm[2:0]];
					`PAT_OP8_BF:
					begin
						if (imm == '0)
							halted = 1'b1;
						else
							next_pc = pc + int'($signed(imm));
					end
					default: ;
				endcase
			end
			else if (ok && w[7:4] != `PAT_PREFIX)
			begin
				case (w[7:4])
					`PAT_OP3_SHL:  acc = acc << sh;
					`PAT_OP3_SHLO: acc = (acc << sh) | ((8'd1 << sh) - 8'd1);
					`PAT_OP3_SHR:  acc = acc >> sh;
					`PAT_OP3_ASR:
					begin
						for (k = 0; k < sh; k++)
							acc = {acc[7], acc[7:1]};    // sign copied down
					end
					`PAT_OP3_IN:   acc = in_val;
					`PAT_OP3_OUT:  exp_q.push_back(acc);
					default: ;
				endcase
			end
			else if (ok)
			begin
				case (w[3:0])
					`PAT_OP0_NOT:  acc = ~acc;
					`PAT_OP0_TEST:
					begin
						z = (acc == '0);
						n = acc[7];
					end
					default: ;
				endcase
			end
			pc = next_pc;
			steps++;
		end
	endfunction

	// ====================================================================
	// comparison
	// ====================================================================
	task automatic check(input string name, input logic [15:0] exp_v,
		input logic [15:0] act_v);
		if (act_v !== exp_v)
		begin
			errors++;
			$display("ERR %s expected %h actual %h", name, exp_v, act_v);
		end
	endtask

	// sample the output port in mid cycle
	always @(negedge clk)
	begin
		if (!reset && o_out_valid === 1'b1)
		begin
			if (out_idx < exp_q.size())
			begin
				check(test_name, 16'(exp_q[out_idx]), 16'(o_out_port));
				checked++;
			end
			out_idx++;
		end
	end

	// load under reset and wait for the predicted outputs
	task automatic run_program(input pat_pkg::data_t in_val);
		int i;
		int cyc;
		predict(in_val);
		@(posedge clk);
		reset     <= 1'b1;
		i_in_port <= in_val;                       // held for the whole run
		out_idx    = 0;
		for (i = 0; i < 16; i++)
		begin
			i_prog <= (i < prog_len) ? {1'b1, i[5:0], prog[i]} : '0;
			@(posedge clk);
		end
		check(test_name, 16'd0, 16'(o_pc));        // fetch restarts at word 0
		reset  <= 1'b0;
		i_prog <= '0;
		cyc = 0;
		while (out_idx < exp_q.size() && cyc < WAIT_LIMIT)
		begin
			@(posedge clk);
			cyc++;
		end
		if (out_idx < exp_q.size())
		begin
			errors++;
			$display("%s timed out with %0d of %0d outputs", test_name, out_idx,
				exp_q.size());
		end
		cyc = 0;
		while (cyc < TAIL)
		begin
			@(posedge clk);
			cyc++;
		end
		if (out_idx > exp_q.size())
		begin
			errors++;
			$display("%s gave %0d outputs but only %0d were expected", test_name, out_idx,
				exp_q.size());
		end
	endtask

	// ====================================================================
	// tests
	// ====================================================================
	initial
	begin
		pat_pkg::data_t v;
		pat_pkg::data_t neg;
		reset     = 1'b1;
		i_prog    = '0;
		i_in_port = '0;
		errors    = 0;
		checked   = 0;
		out_idx   = 0;
		seed      = 32'h2803368b;

		new_program("alu_imm");
		add_word(imm8_word(`PAT_COND_AL, `PAT_OP8_LDI, rand_byte()));
		add_out();
		add_word(imm8_word(`PAT_COND_AL, `PAT_OP8_ADD, rand_byte()));
		add_out();
		add_word(imm8_word(`PAT_COND_AL, `PAT_OP8_SUB, rand_byte()));
		add_out();
		add_word(imm8_word(`PAT_COND_AL, `PAT_OP8_OR, rand_byte()));
		add_out();
		add_word(imm8_word(`PAT_COND_AL, `PAT_OP8_AND, rand_byte()));
		add_out();
		add_word(imm8_word(`PAT_COND_AL, `PAT_OP8_LDI, 8'hc0));
		add_word(imm8_word(`PAT_COND_AL, `PAT_OP8_ADD, rand_byte() | 8'h80));  // must wrap
		add_out();
		add_halt();
		run_program(rand_byte());

		new_program("dmem");
		add_word(imm8_word(`PAT_COND_AL, `PAT_OP8_LDI, rand_byte()));
		add_word(imm8_word(`PAT_COND_AL, `PAT_OP8_STM, 8'd1));
		add_word(imm8_word(`PAT_COND_AL, `PAT_OP8_LDI, rand_byte()));
		add_word(imm8_word(`PAT_COND_AL, `PAT_OP8_STM, 8'd5));
		add_word(imm8_word(`PAT_COND_AL, `PAT_OP8_LDM, 8'd1));
		add_out();
		add_word(imm8_word(`PAT_COND_AL, `PAT_OP8_ADDM, 8'd5));
		add_out();
		add_word(imm8_word(`PAT_COND_AL, `PAT_OP8_SUBM, 8'd1));
		add_out();
		add_word(imm8_word(`PAT_COND_AL, `PAT_OP8_ORM, 8'd5));
		add_out();
		add_word(imm8_word(`PAT_COND_AL, `PAT_OP8_ANDM, 8'd1));
		add_out();
		add_halt();
		run_program(8'h00);

		new_program("shift_not");
		neg = rand_byte() | 8'h80;                 // top bit set for asr
		add_word(imm8_word(`PAT_COND_AL, `PAT_OP8_LDI, neg));
		add_word(imm3_word(`PAT_COND_AL, `PAT_OP3_SHL, 3'd3));
		add_out();
		add_word(imm8_word(`PAT_COND_AL, `PAT_OP8_LDI, neg));
		add_word(imm3_word(`PAT_COND_AL, `PAT_OP3_SHR, 3'd2));
		add_out();
		add_word(imm8_word(`PAT_COND_AL, `PAT_OP8_LDI, neg));
		add_word(imm3_word(`PAT_COND_AL, `PAT_OP3_ASR, 3'd3));
		add_out();
		add_word(imm3_word(`PAT_COND_AL, `PAT_OP3_SHLO, 3'd4));
		add_out();
		add_word(imm0_word(`PAT_COND_AL, `PAT_OP0_NOT));
		add_out();
		add_halt();
		run_program(8'h00);

		new_program("branch");
		add_word(imm8_word(`PAT_COND_AL, `PAT_OP8_LDI, 8'd3));
		add_out();                                 // loop top at word 1
		add_word(imm8_word(`PAT_COND_AL, `PAT_OP8_SUB, 8'd1));
		add_word(imm0_word(`PAT_COND_AL, `PAT_OP0_TEST));
		add_word(imm8_word(`PAT_COND_NZ, `PAT_OP8_BF, 8'hfd));      // back to word 1
		add_word(imm8_word(`PAT_COND_NZ, `PAT_OP8_LDI, 8'h66));     // skipped with z set
		add_word(imm8_word(`PAT_COND_Z, `PAT_OP8_LDI, 8'h80));      // taken with z set
		add_word(imm8_word(`PAT_COND_N, `PAT_OP8_LDI, 8'h77));      // skipped with n clear
		add_out();
		add_word(imm0_word(`PAT_COND_AL, `PAT_OP0_TEST));
		add_word(imm8_word(`PAT_COND_N, `PAT_OP8_BF, 8'h03));
		add_out();                                 // wrong path
		add_out();                                 // wrong path
		add_word(imm8_word(`PAT_COND_Z, `PAT_OP8_ADD, 8'd1));       // skipped with z clear
		add_out();
		add_halt();
		run_program(8'h00);

		new_program("in_port_a");
		add_word(imm3_word(`PAT_COND_AL, `PAT_OP3_IN, 3'd0));
		add_word(imm8_word(`PAT_COND_AL, `PAT_OP8_STM, 8'd6));      // dirty word 6
		add_out();
		add_word(imm8_word(`PAT_COND_AL, `PAT_OP8_ADD, 8'd1));
		add_out();
		add_halt();
		v = rand_byte();
		run_program(v);
		test_name = "in_port_b";
		run_program(~v);

		// fresh program sees cleared state
		new_program("reload");
		add_out();
		add_word(imm8_word(`PAT_COND_AL, `PAT_OP8_LDM, 8'd6));
		add_out();
		add_word(imm8_word(`PAT_COND_AL, `PAT_OP8_LDI, 8'h3c));
		add_out();
		add_halt();
		run_program(8'ha5);

		errors = errors + dut.execute.exec_chk.fails;
		$display("outputs checked %0d, assertion failures %0d, errors %0d", checked,
			dut.execute.exec_chk.fails, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
design/pat_pkg.sv
design/pat_alu.sv
design/pat_fetch.sv
design/pat_decode.sv
design/pat_execute.sv
design/pat_top.sv
test/pat_chk.sv
test/pat_tb.sv

// ==== Bender.yml ====
package:
  name: pat_ctrl

sources:
  - include_dirs:
      - include
    files:
      - design/pat_pkg.sv
      - design/pat_alu.sv
      - design/pat_fetch.sv
      - design/pat_decode.sv
      - design/pat_execute.sv
      - design/pat_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/pat_chk.sv
      - test/pat_tb.sv
